//--- common/ICacheTypes.sv
`default_nettype none

package ICacheTypes;

    // Cache geometry
    localparam int FetchAddrWidth = 16;
    localparam int WordWidth = 32;
    localparam int WordsPerLine = 4;
    localparam int OffsetWidth = 4;
    localparam int IndexWidth = 6;
    localparam int TagWidth = 6;

    // Tag and index together address one line in memory
    localparam int LineAddrWidth = TagWidth + IndexWidth;
    localparam int LineWidth = WordsPerLine * WordWidth;

    // Byte address seen by the fetch port
    typedef logic [FetchAddrWidth-1:0] FetchAddr;

    typedef logic [WordWidth-1:0] Word;
    typedef logic [TagWidth-1:0] Tag;
    typedef logic [IndexWidth-1:0] LineIndex;

    // Tag in the upper bits, index in the lower bits
    typedef logic [LineAddrWidth-1:0] LineAddr;

    // Word 0 sits in the lowest bits
    typedef logic [LineWidth-1:0] Line;

    // Refill sequence
    typedef enum logic [1:0] {
        Idle = 2'h0,
        Invalidate = 2'h1,
        ReadMemory = 2'h2,
        WriteLine = 2'h3
    } RefillState;

endpackage

`default_nettype wire

//--- common/ArrayWriteIf.sv
`default_nettype none

// Write port from the refill engine into the cache array
interface ArrayWriteIf;
    import ICacheTypes::*;

    logic writeEnable;
    LineIndex writeIndex;
    logic writeValid;
    Tag writeTag;
    Line writeData;

    modport refill (
        output writeEnable, writeIndex, writeValid, writeTag, writeData
    );

    modport array (
        input writeEnable, writeIndex, writeValid, writeTag, writeData
    );

endinterface

`default_nettype wire

//--- common/ArrayReadIf.sv
`default_nettype none

// Combinational lookup port used by the fetch unit
interface ArrayReadIf;
    import ICacheTypes::*;

    LineIndex readIndex;
    logic readValid;
    Tag readTag;
    Line readData;

    modport fetch (
        output readIndex,
        input  readValid, readTag, readData
    );

    modport array (
        input  readIndex,
        output readValid, readTag, readData
    );

endinterface

`default_nettype wire

//--- icache/ICacheArray.sv
`default_nettype none

module ICacheArray (
    input  logic       clk,
    input  logic       rst,
    ArrayWriteIf.array wr,
    ArrayReadIf.array  rd
);
    import ICacheTypes::*;

    // Valid bits are cleared by reset
    logic [(1 << IndexWidth)-1:0] validBits;

    // Tag and data storage
    Tag tags [0:(1 << IndexWidth)-1];
    Line lines [0:(1 << IndexWidth)-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
        end else if (wr.writeEnable) begin
            validBits[wr.writeIndex] <= wr.writeValid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.writeEnable) begin
            tags[wr.writeIndex] <= wr.writeTag;
            lines[wr.writeIndex] <= wr.writeData;
        end
    end

    // Combinational read returns the old contents during a write
    always_comb begin
        rd.readValid = validBits[rd.readIndex];
        rd.readTag = tags[rd.readIndex];
        rd.readData = lines[rd.readIndex];
    end

endmodule

`default_nettype wire

//--- icache/ICacheReplacer.sv
`default_nettype none

module ICacheReplacer (
    input  logic                 clk,
    input  logic                 rst,

    // Request from the fetch unit
    input  logic                 refillStart,
    input  ICacheTypes::LineAddr refillAddr,
    output logic                 refillDone,

    // Cache array write port
    ArrayWriteIf.refill          wr,

    // External memory
    output ICacheTypes::LineAddr memAddr,
    output logic                 memReadEnable,
    input  logic                 memReadDone,
    input  ICacheTypes::Line     memReadValue
);
    import ICacheTypes::*;

    RefillState state;
    RefillState nextState;

    // Line being refilled and the data fetched for it
    LineAddr missAddr;
    Line lineBuf;

    always_comb begin
        nextState = state;
        unique case (state)
            Idle: begin
                if (refillStart) begin
                    nextState = Invalidate;
                end
            end
            Invalidate: begin
                nextState = ReadMemory;
            end
            ReadMemory: begin
                if (memReadDone) begin
                    nextState = WriteLine;
                end
            end
            WriteLine: begin
                nextState = Idle;
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == Idle && refillStart) begin
            missAddr <= refillAddr;
        end
        if (state == ReadMemory && memReadDone) begin
            lineBuf <= memReadValue;
        end
    end

    // Invalidate first, so a half-filled line never looks valid
    assign wr.writeEnable = (state == Invalidate) || (state == WriteLine);
    assign wr.writeValid = (state == WriteLine);
    assign wr.writeIndex = missAddr[IndexWidth-1:0];
    assign wr.writeTag = missAddr[LineAddrWidth-1:IndexWidth];
    assign wr.writeData = lineBuf;

    assign memAddr = missAddr;
    assign memReadEnable = (state == ReadMemory);

    // Line lands in the array on the same edge
    assign refillDone = (state == WriteLine);

endmodule

`default_nettype wire

//--- icache/ICacheFetch.sv
`default_nettype none

module ICacheFetch (
    input  logic                  clk,
    input  logic                  rst,

    // Fetch request
    input  logic                  reqValid,
    output logic                  reqReady,
    input  ICacheTypes::FetchAddr reqAddr,

    // Fetch response
    output logic                  rspValid,
    input  logic                  rspReady,
    output ICacheTypes::Word      rspData,

    // Cache array lookup
    ArrayReadIf.fetch             rd,

    // Refill engine control
    output logic                  refillStart,
    output ICacheTypes::LineAddr  refillAddr,
    input  logic                  refillDone
);
    import ICacheTypes::*;

    // Address fields
    Tag reqTag;
    LineIndex reqIndex;
    logic [OffsetWidth-3:0] wordSel;

    logic hit;
    logic idle;
    logic accept;
    logic refilling;
    Word selectedWord;

    // Low two address bits are ignored
    assign reqTag = reqAddr[FetchAddrWidth-1 -: TagWidth];
    assign reqIndex = reqAddr[OffsetWidth +: IndexWidth];
    assign wordSel = reqAddr[OffsetWidth-1:2];

    assign rd.readIndex = reqIndex;
    assign hit = rd.readValid && (rd.readTag == reqTag);
    assign selectedWord = rd.readData[wordSel * WordWidth +: WordWidth];

    // Only one request in flight
    assign idle = !rspValid && !refilling;
    assign reqReady = idle && hit;
    assign accept = reqValid && reqReady;

    // Single pulse since refilling blocks a repeat
    assign refillStart = idle && reqValid && !hit;
    assign refillAddr = {reqTag, reqIndex};

    always_ff @(posedge clk) begin
        if (rst) begin
            refilling <= 1'b0;
        end else if (refillStart) begin
            refilling <= 1'b1;
        end else if (refillDone) begin
            // Retry lookup on the next cycle
            refilling <= 1'b0;
        end
    end

    // Response stays put until the consumer takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            rspValid <= 1'b0;
        end else if (accept) begin
            rspValid <= 1'b1;
        end else if (rspReady) begin
            rspValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rspData <= selectedWord;
        end
    end

endmodule

`default_nettype wire

//--- design/ICache.sv
`default_nettype none

module ICache (
    input  logic                  clk,
    input  logic                  rst,

    // Fetch request
    input  logic                  reqValid,
    output logic                  reqReady,
    input  ICacheTypes::FetchAddr reqAddr,

    // Fetch response
    output logic                  rspValid,
    input  logic                  rspReady,
    output ICacheTypes::Word      rspData,

    // Memory
    output ICacheTypes::LineAddr  memAddr,
    output logic                  memReadEnable,
    input  logic                  memReadDone,
    input  ICacheTypes::Line      memReadValue
);
    import ICacheTypes::*;

    ArrayWriteIf arrayWrite ();
    ArrayReadIf arrayRead ();

    // Refill handshake between fetch and refill engine
    logic refillStart;
    logic refillDone;
    LineAddr refillAddr;

    ICacheArray array (
        .clk (clk),
        .rst (rst),
        .wr  (arrayWrite.array),
        .rd  (arrayRead.array)
    );

    ICacheReplacer replacer (
        .clk           (clk),
        .rst           (rst),
        .refillStart   (refillStart),
        .refillAddr    (refillAddr),
        .refillDone    (refillDone),
        .wr            (arrayWrite.refill),
        .memAddr       (memAddr),
        .memReadEnable (memReadEnable),
        .memReadDone   (memReadDone),
        .memReadValue  (memReadValue)
    );

    ICacheFetch fetch (
        .clk         (clk),
        .rst         (rst),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .reqAddr     (reqAddr),
        .rspValid    (rspValid),
        .rspReady    (rspReady),
        .rspData     (rspData),
        .rd          (arrayRead.fetch),
        .refillStart (refillStart),
        .refillAddr  (refillAddr),
        .refillDone  (refillDone)
    );

endmodule

`default_nettype wire

//--- test/ICacheChk.sv
`default_nettype none

module ICacheChk (
    input logic             clk,
    input logic             rst,
    input logic             reqReady,
    input logic             rspValid,
    input logic             rspReady,
    input ICacheTypes::Word rspData,
    input logic             memReadEnable,
    input logic             memReadDone
);
    import ICacheTypes::*;

    // Held response keeps its data
    rspHeld: assert property (@(posedge clk) disable iff (rst)
        rspValid && !rspReady |=> rspValid && $stable(rspData))
        else $error("response changed while held by back-pressure");

    // Memory request stays up until answered
    memHeld: assert property (@(posedge clk) disable iff (rst)
        memReadEnable && !memReadDone |=> memReadEnable)
        else $error("memReadEnable dropped before memReadDone");

    // No fetch accepted during a refill
    noAcceptInRefill: assert property (@(posedge clk) disable iff (rst)
        memReadEnable |-> !reqReady)
        else $error("reqReady high while memory read in progress");

endmodule

`default_nettype wire

//--- test/ICacheTb.sv
`default_nettype none

module ICacheTb;
    import ICacheTypes::*;

    localparam int NumTests = 20;
    localparam int ResetCycles = 5;
    localparam int TimeoutCycles = ResetCycles + NumTests * 20;

    logic clk = 1'b0;
    logic rst;
    logic reqValid;
    logic reqReady;
    FetchAddr reqAddr;
    logic rspValid;
    logic rspReady;
    Word rspData;
    LineAddr memAddr;
    logic memReadEnable;
    logic memReadDone = 1'b0;
    Line memReadValue = '0;

    // Stimulus table
    string testName [NumTests];
    FetchAddr testAddr [NumTests];
    Word testWord [NumTests];
    int testReads [NumTests];
    int testHold [NumTests];
    int numEntries = 0;

    // Reference model of valid bits and tags
    logic [(1 << IndexWidth)-1:0] refValid;
    Tag refTag [1 << IndexWidth];

    int errors = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int memReads = 0;
    logic memEnPrev = 1'b0;
    logic memBusy = 1'b0;
    int memWait = 0;

    ICache DUT (
        .clk           (clk),
        .rst           (rst),
        .reqValid      (reqValid),
        .reqReady      (reqReady),
        .reqAddr       (reqAddr),
        .rspValid      (rspValid),
        .rspReady      (rspReady),
        .rspData       (rspData),
        .memAddr       (memAddr),
        .memReadEnable (memReadEnable),
        .memReadDone   (memReadDone),
        .memReadValue  (memReadValue)
    );

    bind ICache ICacheChk chk (
        .clk           (clk),
        .rst           (rst),
        .reqReady      (reqReady),
        .rspValid      (rspValid),
        .rspReady      (rspReady),
        .rspData       (rspData),
        .memReadEnable (memReadEnable),
        .memReadDone   (memReadDone)
    );

    always #20 clk = ~clk;

    // Memory word rule puts 4*L + w in the low bits
    function automatic Word memWord(LineAddr l, logic [1:0] w);
        return 32'hA5A50000 ^ {18'h0, l, w};
    endfunction

    function automatic Line lineData(LineAddr l);
        Line data;
        for (int w = 0; w < WordsPerLine; w++) begin
            data[w*WordWidth +: WordWidth] = memWord(l, w[1:0]);
        end
        return data;
    endfunction

    // Returns 1 on a predicted miss and fills the model line
    function automatic int modelAccess(FetchAddr addr);
        LineIndex idx;
        Tag tag;
        idx = addr[OffsetWidth +: IndexWidth];
        tag = addr[FetchAddrWidth-1 -: TagWidth];
        if (refValid[idx] && refTag[idx] == tag) begin
            return 0;
        end
        refValid[idx] = 1'b1;
        refTag[idx] = tag;
        return 1;
    endfunction

    // Negative reads means take the model prediction
    function automatic void addEntry(string name, FetchAddr addr, int reads, int hold);
        int predicted;
        predicted = modelAccess(addr);
        testName[numEntries] = name;
        testAddr[numEntries] = addr;
        testWord[numEntries] = memWord(addr[FetchAddrWidth-1:OffsetWidth], addr[3:2]);
        testReads[numEntries] = (reads < 0) ? predicted : reads;
        testHold[numEntries] = hold;
        numEntries++;
    endfunction

    function automatic void buildTable();
        FetchAddr addr;
        refValid = '0;
        addEntry("cold miss", 16'h0124, 1, 0);
        addEntry("hit word 0", 16'h0120, 0, 0);
        addEntry("hit word 2", 16'h0128, 0, 0);
        addEntry("hit word 3", 16'h012C, 0, 0);
        addEntry("conflict miss", 16'h4124, 1, 0);
        addEntry("conflict return", 16'h0124, 1, 0);
        addEntry("held hit", 16'h0128, 0, 4);
        addEntry("held miss", 16'h2340, 1, 3);
        // Two indexes and three tags mix hits and conflicts
        while (numEntries < NumTests) begin
            addr = {Tag'($urandom % 3), ($urandom % 2 == 0) ? LineIndex'(3) : LineIndex'(5),
                    2'($urandom % 4), 2'($urandom % 4)};
            addEntry($sformatf("random %0d", numEntries), addr, -1, 0);
        end
    endfunction

    // Memory model with a random answer delay
    always @(posedge clk) begin
        memReadDone <= 1'b0;
        if (memReadEnable && !memReadDone) begin
            if (!memBusy) begin
                memBusy <= 1'b1;
                memWait <= int'($urandom % 6);
            end else if (memWait == 0) begin
                memBusy <= 1'b0;
                memReadDone <= 1'b1;
                memReadValue <= lineData(memAddr);
            end else begin
                memWait <= memWait - 1;
            end
        end
    end

    // Count memory reads at rising edges of memReadEnable
    always @(posedge clk) begin
        memEnPrev <= memReadEnable;
        if (memReadEnable && !memEnPrev) begin
            memReads <= memReads + 1;
        end
    end

    task automatic runTest(input int i);
        int readsBefore;
        int errorsBefore;
        Word heldData;
        errorsBefore = errors;
        @(posedge clk);
        readsBefore = memReads;
        reqValid <= 1'b1;
        reqAddr <= testAddr[i];
        forever begin
            @(posedge clk);
            if (reqValid && reqReady) break;
        end
        if (testHold[i] > 0) begin
            // Offer a second request while the response is held
            rspReady <= 1'b0;
            reqAddr <= testAddr[i] ^ 16'h0004;
        end else begin
            reqValid <= 1'b0;
        end
        @(posedge clk);
        assert (rspValid) else begin
            $display("%s: response not valid one cycle after acceptance", testName[i]);
            errors++;
        end
        if (testHold[i] > 0) begin
            heldData = rspData;
            repeat (testHold[i]) begin
                @(posedge clk);
                assert (rspValid && rspData == heldData) else begin
                    $display("FAIL %s held data: expected %h, actual %h",
                             testName[i], heldData, rspData);
                    errors++;
                end
                assert (!reqReady) else begin
                    $display("%s: new request accepted while response held", testName[i]);
                    errors++;
                end
            end
            rspReady <= 1'b1;
            reqValid <= 1'b0;
            @(posedge clk);
        end
        assert (rspValid && rspData == testWord[i]) else begin
            $display("FAIL %s data: expected %h, actual %h", testName[i], testWord[i], rspData);
            errors++;
        end
        assert (memReads - readsBefore == testReads[i]) else begin
            $display("FAIL %s reads: expected %0d, actual %0d",
                     testName[i], testReads[i], memReads - readsBefore);
            errors++;
        end
        if (errors == errorsBefore) begin
            testsPassed++;
            $display("Test %0d %s: passed", i, testName[i]);
        end else begin
            testsFailed++;
            $display("Test %0d %s: failed", i, testName[i]);
        end
    endtask

    initial begin
        void'($urandom(32'heb81));
        rst = 1'b1;
        reqValid = 1'b0;
        reqAddr = '0;
        rspReady = 1'b1;
        buildTable();
        // First edge loads the reset values
        @(posedge clk);
        repeat (ResetCycles - 1) begin
            @(posedge clk);
            assert (!memReadEnable && !rspValid && !reqReady) else begin
                $display("Outputs not idle during reset");
                errors++;
            end
        end
        rst <= 1'b0;
        for (int i = 0; i < NumTests; i++) begin
            runTest(i);
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 NumTests, testsPassed, testsFailed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not finish", TimeoutCycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
common/ICacheTypes.sv
common/ArrayWriteIf.sv
common/ArrayReadIf.sv
icache/ICacheArray.sv
icache/ICacheReplacer.sv
icache/ICacheFetch.sv
design/ICache.sv
test/ICacheChk.sv
test/ICacheTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -f project.f --top-module ICacheTb

# The simulator may stop early on an assertion, the log decides
./obj_dir/VICacheTb | tee sim.log || true

if grep -q '>>> PASS' sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
